// ==== common/trace_pkg.sv ====
// Trace unit types: word and register ids, opcode constants, immediate and memory enums, records
`default_nettype none

package trace_pkg;

  typedef logic [31:0] xlen_word_t;
  // Top bit marks a floating-point register
  typedef logic [5:0] reg_id_t;
  typedef logic [4:0] arch_reg_t;
  typedef logic [3:0] byte_mask_t;
  typedef logic [6:0] opcode_t;

  localparam opcode_t OPCODE_LUI      = 7'h37;
  localparam opcode_t OPCODE_AUIPC    = 7'h17;
  localparam opcode_t OPCODE_JAL      = 7'h6f;
  localparam opcode_t OPCODE_JALR     = 7'h67;
  localparam opcode_t OPCODE_BRANCH   = 7'h63;
  localparam opcode_t OPCODE_LOAD     = 7'h03;
  localparam opcode_t OPCODE_STORE    = 7'h23;
  localparam opcode_t OPCODE_OP_IMM   = 7'h13;
  localparam opcode_t OPCODE_OP       = 7'h33;
  localparam opcode_t OPCODE_SYSTEM   = 7'h73;
  localparam opcode_t OPCODE_LOAD_FP  = 7'h07;
  localparam opcode_t OPCODE_STORE_FP = 7'h27;

  // IZ is the zero-extended CSR form
  typedef enum logic [2:0] {
    IMM_NONE,
    IMM_I,
    IMM_IZ,
    IMM_S,
    IMM_B,
    IMM_U,
    IMM_J,
    IMM_SHAMT
  } imm_fmt_e;

  typedef enum logic [1:0] {
    MEM_NONE,
    MEM_LOAD,
    MEM_STORE
  } mem_kind_e;

  // Retirement port fields, strobe excluded
  typedef struct packed {
    xlen_word_t             insn;
    xlen_word_t             pc_rdata;
    arch_reg_t  [1:0]       rd_addr;
    xlen_word_t [1:0]       rd_wdata;
    logic       [1:0]       frd_wvalid;
    arch_reg_t  [1:0]       frd_addr;
    xlen_word_t [1:0]       frd_wdata;
    arch_reg_t              rs1_addr;
    arch_reg_t              rs2_addr;
    arch_reg_t              rs3_addr;
    xlen_word_t             rs1_rdata;
    xlen_word_t             rs2_rdata;
    xlen_word_t             rs3_rdata;
    logic                   frs1_rvalid;
    logic                   frs2_rvalid;
    logic                   frs3_rvalid;
    arch_reg_t              frs1_addr;
    arch_reg_t              frs2_addr;
    arch_reg_t              frs3_addr;
    xlen_word_t             frs1_rdata;
    xlen_word_t             frs2_rdata;
    xlen_word_t             frs3_rdata;
    xlen_word_t             mem_addr;
    byte_mask_t             mem_rmask;
    byte_mask_t             mem_wmask;
    xlen_word_t             mem_rdata;
    xlen_word_t             mem_wdata;
  } rvfi_retire_t;

  typedef struct packed {
    xlen_word_t hart_id;
    xlen_word_t cycle;
    xlen_word_t pc;
    xlen_word_t instr;
    logic       compressed;
    logic       c_illegal;
    reg_id_t    rd;
    xlen_word_t rd_value;
    logic       rd2_valid;
    reg_id_t    rd2;
    xlen_word_t rd2_value;
    reg_id_t    rs1;
    reg_id_t    rs2;
    reg_id_t    rs3;
    xlen_word_t rs1_value;
    xlen_word_t rs2_value;
    xlen_word_t rs3_value;
    imm_fmt_e   imm_fmt;
    xlen_word_t imm;
    mem_kind_e  mem_kind;
    xlen_word_t mem_addr;
    xlen_word_t mem_data;
  } trace_record_t;

  typedef struct packed {
    xlen_word_t retired;
    xlen_word_t compressed;
    xlen_word_t c_illegal;
    xlen_word_t loads;
    xlen_word_t stores;
    xlen_word_t fp_writes;
  } trace_stats_t;

endpackage

`default_nettype wire

// ==== trace/compressed_decoder.sv ====
// RV32C to 32-bit instruction expander with optional C.FLW/C.FSW support and illegal flag
`timescale 1ns/1ps
`default_nettype none

module compressed_decoder #(
  parameter int unsigned FPU = 1
) (
  input  trace_pkg::xlen_word_t instr_i,
  output trace_pkg::xlen_word_t instr_o,
  output logic                  is_compressed_o,
  output logic                  illegal_o
);

  import trace_pkg::*;

  localparam bit FP_EN = (FPU != 0);

  logic [15:0] c;
  xlen_word_t  expanded;
  logic        illegal;

  assign c = instr_i[15:0];

  always_comb begin
    expanded = instr_i;
    illegal  = 1'b0;
    if (instr_i[1:0] != 2'b11) begin
      unique case ({c[1:0], c[15:13]})
        // Quadrant 0
        5'b00_000: begin
          // C.ADDI4SPN, zero immediate is reserved
          expanded = {2'b0, c[10:7], c[12:11], c[5], c[6], 2'b00, 5'h02, 3'b000,
                      2'b01, c[4:2], OPCODE_OP_IMM};
          illegal  = (c[12:5] == 8'h00);
        end
        5'b00_010: begin
          expanded = {5'b0, c[5], c[12:10], c[6], 2'b00, 2'b01, c[9:7], 3'b010,
                      2'b01, c[4:2], OPCODE_LOAD};
        end
        5'b00_011: begin
          expanded = {5'b0, c[5], c[12:10], c[6], 2'b00, 2'b01, c[9:7], 3'b010,
                      2'b01, c[4:2], OPCODE_LOAD_FP};
          illegal  = !FP_EN;
        end
        5'b00_110: begin
          expanded = {5'b0, c[5], c[12], 2'b01, c[4:2], 2'b01, c[9:7], 3'b010,
                      c[11:10], c[6], 2'b00, OPCODE_STORE};
        end
        5'b00_111: begin
          expanded = {5'b0, c[5], c[12], 2'b01, c[4:2], 2'b01, c[9:7], 3'b010,
                      c[11:10], c[6], 2'b00, OPCODE_STORE_FP};
          illegal  = !FP_EN;
        end
        // Quadrant 1
        5'b01_000: begin
          expanded = {{6{c[12]}}, c[12], c[6:2], c[11:7], 3'b000, c[11:7], OPCODE_OP_IMM};
        end
        5'b01_001, 5'b01_101: begin
          // C.JAL links to x1, C.J to x0
          expanded = {c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3], {9{c[12]}},
                      4'b0, ~c[15], OPCODE_JAL};
        end
        5'b01_010: begin
          expanded = {{6{c[12]}}, c[12], c[6:2], 5'b0, 3'b000, c[11:7], OPCODE_OP_IMM};
        end
        5'b01_011: begin
          if (c[11:7] == 5'h02) begin
            expanded = {{3{c[12]}}, c[4:3], c[5], c[2], c[6], 4'b0, 5'h02, 3'b000,
                        5'h02, OPCODE_OP_IMM};
          end else begin
            expanded = {{15{c[12]}}, c[6:2], c[11:7], OPCODE_LUI};
          end
          illegal = ({c[12], c[6:2]} == 6'h00);
        end
        5'b01_100: begin
          unique case (c[11:10])
            2'b00, 2'b01: begin
              // C.SRLI and C.SRAI, shamt[5] must be clear on RV32
              expanded = {1'b0, c[10], 5'b0, c[6:2], 2'b01, c[9:7], 3'b101, 2'b01, c[9:7],
                          OPCODE_OP_IMM};
              illegal  = c[12];
            end
            2'b10: begin
              expanded = {{6{c[12]}}, c[12], c[6:2], 2'b01, c[9:7], 3'b111, 2'b01, c[9:7],
                          OPCODE_OP_IMM};
            end
            default: begin
              unique case (c[6:5])
                2'b00: expanded = {2'b01, 5'b0, 2'b01, c[4:2], 2'b01, c[9:7], 3'b000,
                                   2'b01, c[9:7], OPCODE_OP};
                2'b01: expanded = {7'b0, 2'b01, c[4:2], 2'b01, c[9:7], 3'b100,
                                   2'b01, c[9:7], OPCODE_OP};
                2'b10: expanded = {7'b0, 2'b01, c[4:2], 2'b01, c[9:7], 3'b110,
                                   2'b01, c[9:7], OPCODE_OP};
                default: expanded = {7'b0, 2'b01, c[4:2], 2'b01, c[9:7], 3'b111,
                                     2'b01, c[9:7], OPCODE_OP};
              endcase
              // Word forms belong to RV64
              illegal = c[12];
            end
          endcase
        end
        5'b01_110, 5'b01_111: begin
          expanded = {{4{c[12]}}, c[6:5], c[2], 5'b0, 2'b01, c[9:7], 2'b00, c[13],
                      c[11:10], c[4:3], c[12], OPCODE_BRANCH};
        end
        // Quadrant 2
        5'b10_000: begin
          expanded = {7'b0, c[6:2], c[11:7], 3'b001, c[11:7], OPCODE_OP_IMM};
          illegal  = c[12];
        end
        5'b10_010: begin
          expanded = {4'b0, c[3:2], c[12], c[6:4], 2'b00, 5'h02, 3'b010, c[11:7],
                      OPCODE_LOAD};
          illegal  = (c[11:7] == 5'h00);
        end
        5'b10_011: begin
          expanded = {4'b0, c[3:2], c[12], c[6:4], 2'b00, 5'h02, 3'b010, c[11:7],
                      OPCODE_LOAD_FP};
          illegal  = !FP_EN;
        end
        5'b10_100: begin
          if (!c[12]) begin
            if (c[6:2] == 5'h00) begin
              // C.JR
              expanded = {12'b0, c[11:7], 3'b000, 5'h00, OPCODE_JALR};
              illegal  = (c[11:7] == 5'h00);
            end else begin
              expanded = {7'b0, c[6:2], 5'h00, 3'b000, c[11:7], OPCODE_OP};
            end
          end else if (c[6:2] == 5'h00) begin
            if (c[11:7] == 5'h00) begin
              expanded = 32'h0010_0073;
            end else begin
              expanded = {12'b0, c[11:7], 3'b000, 5'h01, OPCODE_JALR};
            end
          end else begin
            expanded = {7'b0, c[6:2], c[11:7], 3'b000, c[11:7], OPCODE_OP};
          end
        end
        5'b10_110: begin
          expanded = {4'b0, c[8:7], c[12], c[6:2], 5'h02, 3'b010, c[11:9], 2'b00,
                      OPCODE_STORE};
        end
        5'b10_111: begin
          expanded = {4'b0, c[8:7], c[12], c[6:2], 5'h02, 3'b010, c[11:9], 2'b00,
                      OPCODE_STORE_FP};
          illegal  = !FP_EN;
        end
        // C.FLD, C.FSD, their SP forms and the reserved slot
        default: illegal = 1'b1;
      endcase
    end
  end

  assign is_compressed_o = (instr_i[1:0] != 2'b11);
  assign illegal_o       = illegal;
  // Illegal encodings leave the raw word visible in the trace
  assign instr_o         = illegal ? instr_i : expanded;

  expand_ok_a: assert final ($isunknown(instr_i) || illegal_o || instr_o[1:0] == 2'b11)
    else $error("Legal expansion without a 32-bit opcode");

endmodule

`default_nettype wire

// ==== trace/trace_record_builder.sv ====
// Trace record builder: operand merge, immediate extraction, memory class, cycle stamp, record reg
`timescale 1ns/1ps
`default_nettype none

module trace_record_builder #(
  parameter int unsigned FPU = 1
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  trace_pkg::xlen_word_t    hart_id_i,
  input  logic                     rvfi_valid_i,
  input  trace_pkg::rvfi_retire_t  rvfi_i,
  output logic                     trace_valid_o,
  output trace_pkg::trace_record_t trace_o
);

  import trace_pkg::*;

  localparam bit FP_EN = (FPU != 0);

  xlen_word_t    instr_exp;
  logic          is_compressed;
  logic          c_illegal;
  opcode_t       opcode;
  logic [2:0]    funct3;
  logic          rs1_fp;
  logic          rs2_fp;
  logic          rs3_fp;
  logic          rd_fp;
  logic          rd2_fp;
  xlen_word_t    imm_i;
  xlen_word_t    imm_iz;
  xlen_word_t    imm_s;
  xlen_word_t    imm_b;
  xlen_word_t    imm_u;
  xlen_word_t    imm_j;
  xlen_word_t    imm_shamt;
  imm_fmt_e      imm_fmt;
  xlen_word_t    cycle_q;
  logic          valid_q;
  trace_record_t rec_d;
  trace_record_t rec_q;

  compressed_decoder #(
    .FPU(FPU)
  ) decomp_i (
    .instr_i        (rvfi_i.insn),
    .instr_o        (instr_exp),
    .is_compressed_o(is_compressed),
    .illegal_o      (c_illegal)
  );

  // FP port flags only count when the core has an FPU
  assign rs1_fp = FP_EN && rvfi_i.frs1_rvalid;
  assign rs2_fp = FP_EN && rvfi_i.frs2_rvalid;
  assign rs3_fp = FP_EN && rvfi_i.frs3_rvalid;
  assign rd_fp  = FP_EN && rvfi_i.frd_wvalid[0];
  assign rd2_fp = FP_EN && rvfi_i.frd_wvalid[1];

  assign opcode = instr_exp[6:0];
  assign funct3 = instr_exp[14:12];

  assign imm_i     = {{20{instr_exp[31]}}, instr_exp[31:20]};
  assign imm_iz    = {20'b0, instr_exp[31:20]};
  assign imm_s     = {{20{instr_exp[31]}}, instr_exp[31:25], instr_exp[11:7]};
  assign imm_b     = {{19{instr_exp[31]}}, instr_exp[31], instr_exp[7], instr_exp[30:25],
                      instr_exp[11:8], 1'b0};
  assign imm_u     = {instr_exp[31:12], 12'b0};
  assign imm_j     = {{11{instr_exp[31]}}, instr_exp[31], instr_exp[19:12], instr_exp[20],
                      instr_exp[30:21], 1'b0};
  assign imm_shamt = {27'b0, instr_exp[24:20]};

  // Format follows the expanded opcode, so compressed forms decode the same way
  always_comb begin
    case (opcode)
      OPCODE_LUI, OPCODE_AUIPC:              imm_fmt = IMM_U;
      OPCODE_JAL:                            imm_fmt = IMM_J;
      OPCODE_BRANCH:                         imm_fmt = IMM_B;
      OPCODE_STORE, OPCODE_STORE_FP:         imm_fmt = IMM_S;
      OPCODE_OP_IMM: begin
        if (funct3 == 3'b001 || funct3 == 3'b101) begin
          imm_fmt = IMM_SHAMT;
        end else begin
          imm_fmt = IMM_I;
        end
      end
      OPCODE_LOAD, OPCODE_LOAD_FP, OPCODE_JALR: imm_fmt = IMM_I;
      OPCODE_SYSTEM: imm_fmt = (funct3 != 3'b000) ? IMM_IZ : IMM_NONE;
      default:       imm_fmt = IMM_NONE;
    endcase
  end

  always_comb begin
    rec_d            = '0;
    rec_d.hart_id    = hart_id_i;
    rec_d.cycle      = cycle_q;
    rec_d.pc         = rvfi_i.pc_rdata;
    rec_d.instr      = instr_exp;
    rec_d.compressed = is_compressed;
    rec_d.c_illegal  = c_illegal;

    // Merged register numbering
    rec_d.rs1       = rs1_fp ? {1'b1, rvfi_i.frs1_addr} : {1'b0, rvfi_i.rs1_addr};
    rec_d.rs2       = rs2_fp ? {1'b1, rvfi_i.frs2_addr} : {1'b0, rvfi_i.rs2_addr};
    rec_d.rs3       = rs3_fp ? {1'b1, rvfi_i.frs3_addr} : {1'b0, rvfi_i.rs3_addr};
    rec_d.rs1_value = rs1_fp ? rvfi_i.frs1_rdata : rvfi_i.rs1_rdata;
    rec_d.rs2_value = rs2_fp ? rvfi_i.frs2_rdata : rvfi_i.rs2_rdata;
    rec_d.rs3_value = rs3_fp ? rvfi_i.frs3_rdata : rvfi_i.rs3_rdata;
    rec_d.rd        = rd_fp ? {1'b1, rvfi_i.frd_addr[0]} : {1'b0, rvfi_i.rd_addr[0]};
    rec_d.rd_value  = rd_fp ? rvfi_i.frd_wdata[0] : rvfi_i.rd_wdata[0];
    rec_d.rd2       = rd2_fp ? {1'b1, rvfi_i.frd_addr[1]} : {1'b0, rvfi_i.rd_addr[1]};
    rec_d.rd2_value = rd2_fp ? rvfi_i.frd_wdata[1] : rvfi_i.rd_wdata[1];
    rec_d.rd2_valid = rd2_fp || (rvfi_i.rd_addr[1] != 5'h00);

    rec_d.imm_fmt = imm_fmt;
    case (imm_fmt)
      IMM_I:     rec_d.imm = imm_i;
      IMM_IZ:    rec_d.imm = imm_iz;
      IMM_S:     rec_d.imm = imm_s;
      IMM_B:     rec_d.imm = imm_b;
      IMM_U:     rec_d.imm = imm_u;
      IMM_J:     rec_d.imm = imm_j;
      IMM_SHAMT: rec_d.imm = imm_shamt;
      default:   rec_d.imm = '0;
    endcase

    // A write mask wins over a read mask
    if (|rvfi_i.mem_wmask) begin
      rec_d.mem_kind = MEM_STORE;
      rec_d.mem_addr = rvfi_i.mem_addr;
      rec_d.mem_data = rvfi_i.mem_wdata;
    end else if (|rvfi_i.mem_rmask) begin
      rec_d.mem_kind = MEM_LOAD;
      rec_d.mem_addr = rvfi_i.mem_addr;
      rec_d.mem_data = rvfi_i.mem_rdata;
    end
  end

  // Stamp holds the number of edges completed before the sampling edge
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cycle_q <= '0;
      valid_q <= 1'b0;
    end else begin
      cycle_q <= cycle_q + 32'd1;
      valid_q <= rvfi_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rvfi_valid_i) begin
      rec_q <= rec_d;
    end
  end

  assign trace_valid_o = valid_q;
  assign trace_o       = rec_q;

  // The core never reads and writes memory in one retirement
  mask_exclusive_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rvfi_valid_i |-> !((|rvfi_i.mem_rmask) && (|rvfi_i.mem_wmask)))
    else $error("Retirement with both read and write masks set");

endmodule

`default_nettype wire

// ==== src/trace_stats.sv ====
// Saturating retirement statistics counters fed by the trace record stream
`timescale 1ns/1ps
`default_nettype none

module trace_stats (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     trace_valid_i,
  input  trace_pkg::trace_record_t trace_i,
  output trace_pkg::trace_stats_t  stats_o
);

  import trace_pkg::*;

  trace_stats_t stats_q;
  logic [1:0]   fp_inc;

  function automatic xlen_word_t sat_add(input xlen_word_t value, input logic [1:0] inc);
    logic [32:0] sum;
    sum = {1'b0, value} + {31'b0, inc};
    return sum[32] ? '1 : sum[31:0];
  endfunction

  // Up to two FP writes per retirement
  assign fp_inc = {1'b0, trace_i.rd[5]} + {1'b0, trace_i.rd2_valid & trace_i.rd2[5]};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      stats_q <= '0;
    end else if (trace_valid_i) begin
      stats_q.retired    <= sat_add(stats_q.retired, 2'd1);
      stats_q.compressed <= sat_add(stats_q.compressed, {1'b0, trace_i.compressed});
      stats_q.c_illegal  <= sat_add(stats_q.c_illegal, {1'b0, trace_i.c_illegal});
      stats_q.loads      <= sat_add(stats_q.loads, {1'b0, trace_i.mem_kind == MEM_LOAD});
      stats_q.stores     <= sat_add(stats_q.stores, {1'b0, trace_i.mem_kind == MEM_STORE});
      stats_q.fp_writes  <= sat_add(stats_q.fp_writes, fp_inc);
    end
  end

  assign stats_o = stats_q;

  // fp_writes is left out since it can outpace retired
  count_order_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    stats_q.retired >= stats_q.compressed &&
    stats_q.compressed >= stats_q.c_illegal &&
    stats_q.retired >= stats_q.loads &&
    stats_q.retired >= stats_q.stores)
    else $error("Event count exceeds retired count");

endmodule

`default_nettype wire

// ==== src/rvfi_trace_top.sv ====
// Retirement trace unit top level joining the record builder and statistics counters
`timescale 1ns/1ps
`default_nettype none

module rvfi_trace_top #(
  parameter int unsigned FPU = 1
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  trace_pkg::xlen_word_t    hart_id_i,
  input  logic                     rvfi_valid_i,
  input  trace_pkg::rvfi_retire_t  rvfi_i,
  output logic                     trace_valid_o,
  output trace_pkg::trace_record_t trace_o,
  output trace_pkg::trace_stats_t  stats_o
);

  // Record is produced one cycle after the strobe
  trace_record_builder #(
    .FPU(FPU)
  ) builder_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .hart_id_i    (hart_id_i),
    .rvfi_valid_i (rvfi_valid_i),
    .rvfi_i       (rvfi_i),
    .trace_valid_o(trace_valid_o),
    .trace_o      (trace_o)
  );

  // Counts trail the record by one more cycle
  trace_stats stats_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .trace_valid_i(trace_valid_o),
    .trace_i      (trace_o),
    .stats_o      (stats_o)
  );

endmodule

`default_nettype wire

// ==== tb/tb_rvfi_trace.sv ====
// Testbench for the retirement trace unit: reference model, random and table stimulus, assertions
`timescale 1ns/1ps
`default_nettype none

module tb_rvfi_trace;

  import trace_pkg::*;

  localparam xlen_word_t HART_ID  = 32'h0000_0003;
  localparam int N_UNCOMP         = 100;
  localparam int N_TABLE          = 12;
  localparam int N_MERGE          = 95;
  localparam int N_MEM            = 95;
  localparam int N_TOTAL          = N_UNCOMP + N_TABLE + N_MERGE + N_MEM;
  // At most two cycles per retirement plus reset and drain margin
  localparam int TIMEOUT_CYCLES   = 6 * N_TOTAL + 200;
  localparam logic [2:0] T_RESET  = 3'd0;
  localparam logic [2:0] T_UNCOMP = 3'd1;
  localparam logic [2:0] T_COMP   = 3'd2;
  localparam logic [2:0] T_MERGE  = 3'd3;
  localparam logic [2:0] T_MEM    = 3'd4;

  logic          clk_i;
  logic          rst_ni;
  xlen_word_t    hart_id_i;
  logic          rvfi_valid_i;
  rvfi_retire_t  rvfi_i;
  logic          trace_valid_o;
  trace_record_t trace_o;
  trace_stats_t  stats_o;

  trace_record_t exp_d;
  trace_record_t exp_next;
  trace_record_t exp_q;
  trace_stats_t  tally_q;
  xlen_word_t    tb_cycle;
  xlen_word_t    rng_state = 32'h7b0;
  logic          strobe_q;
  logic [2:0]    cur_test;
  logic [2:0]    test_q;
  int            errors = 0;
  int            issued = 0;
  int            seen;
  int            cyc = 0;

  // C.ADDI, C.LI, C.LW, C.SW, C.J, C.BEQZ, C.MV, C.ADD, C.SLLI, C.FLW, C.FSW, reserved
  logic [15:0] c_half [N_TABLE] = '{16'h10fd, 16'h451d, 16'h4044, 16'hc404, 16'hbffd,
      16'hc011, 16'h852e, 16'h952e, 16'h028e, 16'h6044, 16'he404, 16'h0000};
  xlen_word_t  c_word [N_TABLE] = '{32'hfff0_8093, 32'h0070_0513, 32'h0044_2483,
      32'h0094_2423, 32'hffff_f06f, 32'h0004_0263, 32'h00b0_0533, 32'h00b5_0533,
      32'h0032_9293, 32'h0044_2487, 32'h0094_2427, 32'h0000_0000};

  rvfi_trace_top #(
    .FPU(1)
  ) dut_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .hart_id_i    (hart_id_i),
    .rvfi_valid_i (rvfi_valid_i),
    .rvfi_i       (rvfi_i),
    .trace_valid_o(trace_valid_o),
    .trace_o      (trace_o),
    .stats_o      (stats_o)
  );

  always #2 clk_i = ~clk_i;

  function automatic xlen_word_t rand32();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic string test_name(input logic [2:0] id);
    case (id)
      T_UNCOMP: return "uncompressed";
      T_COMP:   return "compressed";
      T_MERGE:  return "reg_merge";
      T_MEM:    return "mem_class";
      default:  return "reset";
    endcase
  endfunction

  function automatic imm_fmt_e fmt_of(input xlen_word_t ins);
    case (ins[6:0])
      OPCODE_LUI, OPCODE_AUIPC:                 return IMM_U;
      OPCODE_JAL:                               return IMM_J;
      OPCODE_BRANCH:                            return IMM_B;
      OPCODE_STORE, OPCODE_STORE_FP:            return IMM_S;
      OPCODE_LOAD, OPCODE_LOAD_FP, OPCODE_JALR: return IMM_I;
      OPCODE_OP_IMM: return (ins[14:12] == 3'b001 || ins[14:12] == 3'b101) ? IMM_SHAMT : IMM_I;
      OPCODE_SYSTEM: return (ins[14:12] != 3'b000) ? IMM_IZ : IMM_NONE;
      default:       return IMM_NONE;
    endcase
  endfunction

  function automatic xlen_word_t imm_of(input xlen_word_t ins, input imm_fmt_e fmt);
    xlen_word_t sext;
    // Upper bits all copies of the sign, low 12 bits from ins[31:20]
    sext = $signed(ins) >>> 20;
    case (fmt)
      IMM_I:     return sext;
      IMM_IZ:    return ins >> 20;
      IMM_S:     return {sext[31:5], ins[11:7]};
      IMM_B:     return {sext[31:12], ins[7], ins[30:25], ins[11:8], 1'b0};
      IMM_U:     return {ins[31:12], 12'h000};
      IMM_J:     return {sext[31:20], ins[19:12], ins[20], ins[30:21], 1'b0};
      IMM_SHAMT: return {27'h0, ins[24:20]};
      default:   return '0;
    endcase
  endfunction

  // Expected record for one retirement, cycle stamp added at capture
  function automatic trace_record_t model_record(input rvfi_retire_t r, input xlen_word_t ins,
                                                 input logic comp, input logic ill);
    trace_record_t e;
    e            = '0;
    e.hart_id    = HART_ID;
    e.pc         = r.pc_rdata;
    e.instr      = ins;
    e.compressed = comp;
    e.c_illegal  = ill;
    e.rs1        = r.frs1_rvalid ? {1'b1, r.frs1_addr} : {1'b0, r.rs1_addr};
    e.rs2        = r.frs2_rvalid ? {1'b1, r.frs2_addr} : {1'b0, r.rs2_addr};
    e.rs3        = r.frs3_rvalid ? {1'b1, r.frs3_addr} : {1'b0, r.rs3_addr};
    e.rs1_value  = r.frs1_rvalid ? r.frs1_rdata : r.rs1_rdata;
    e.rs2_value  = r.frs2_rvalid ? r.frs2_rdata : r.rs2_rdata;
    e.rs3_value  = r.frs3_rvalid ? r.frs3_rdata : r.rs3_rdata;
    e.rd         = r.frd_wvalid[0] ? {1'b1, r.frd_addr[0]} : {1'b0, r.rd_addr[0]};
    e.rd_value   = r.frd_wvalid[0] ? r.frd_wdata[0] : r.rd_wdata[0];
    e.rd2        = r.frd_wvalid[1] ? {1'b1, r.frd_addr[1]} : {1'b0, r.rd_addr[1]};
    e.rd2_value  = r.frd_wvalid[1] ? r.frd_wdata[1] : r.rd_wdata[1];
    e.rd2_valid  = r.frd_wvalid[1] || (r.rd_addr[1] != 5'h00);
    e.imm_fmt    = fmt_of(ins);
    e.imm        = imm_of(ins, e.imm_fmt);
    if (r.mem_wmask != 4'h0) begin
      e.mem_kind = MEM_STORE;
      e.mem_addr = r.mem_addr;
      e.mem_data = r.mem_wdata;
    end else if (r.mem_rmask != 4'h0) begin
      e.mem_kind = MEM_LOAD;
      e.mem_addr = r.mem_addr;
      e.mem_data = r.mem_rdata;
    end
    return e;
  endfunction

  function automatic xlen_word_t random_insn();
    xlen_word_t k;
    xlen_word_t w;
    opcode_t    op;
    k = rand32();
    w = rand32();
    case (k[3:0])
      4'd0:    op = OPCODE_LUI;
      4'd1:    op = OPCODE_AUIPC;
      4'd2:    op = OPCODE_JAL;
      4'd3:    op = OPCODE_JALR;
      4'd4:    op = OPCODE_BRANCH;
      4'd5:    op = OPCODE_LOAD;
      4'd6:    op = OPCODE_STORE;
      4'd7:    op = OPCODE_OP;
      4'd8:    op = OPCODE_SYSTEM;
      4'd9:    op = OPCODE_LOAD_FP;
      4'd10:   op = OPCODE_STORE_FP;
      default: op = OPCODE_OP_IMM;
    endcase
    return {w[31:7], op};
  endfunction

  // Random port fields; read and write masks are never both nonzero
  function automatic rvfi_retire_t random_retire(input xlen_word_t insn);
    rvfi_retire_t r;
    xlen_word_t   k;
    byte_mask_t   mask;
    r             = '0;
    r.insn        = insn;
    r.pc_rdata    = rand32() & 32'hffff_fffe;
    k             = rand32();
    r.rd_addr[0]  = k[4:0];
    r.rd_addr[1]  = k[5] ? k[10:6] : 5'h00;
    r.frd_wvalid  = k[12:11];
    r.frd_addr[0] = k[17:13];
    r.frd_addr[1] = k[22:18];
    r.rs1_addr    = k[27:23];
    {r.frs1_rvalid, r.frs2_rvalid, r.frs3_rvalid} = k[30:28];
    k             = rand32();
    r.rs2_addr    = k[4:0];
    r.rs3_addr    = k[9:5];
    r.frs1_addr   = k[14:10];
    r.frs2_addr   = k[19:15];
    r.frs3_addr   = k[24:20];
    mask          = (k[28:25] == 4'h0) ? 4'hf : k[28:25];
    r.mem_rmask   = (k[30:29] == 2'd1) ? mask : 4'h0;
    r.mem_wmask   = (k[30:29] == 2'd2) ? mask : 4'h0;
    r.rd_wdata[0] = rand32();
    r.rd_wdata[1] = rand32();
    r.frd_wdata[0] = rand32();
    r.frd_wdata[1] = rand32();
    r.rs1_rdata   = rand32();
    r.rs2_rdata   = rand32();
    r.rs3_rdata   = rand32();
    r.frs1_rdata  = rand32();
    r.frs2_rdata  = rand32();
    r.frs3_rdata  = rand32();
    r.mem_addr    = rand32();
    r.mem_rdata   = rand32();
    r.mem_wdata   = rand32();
    return r;
  endfunction

  function automatic logic [255:0] instr_view(input trace_record_t r);
    return 256'({r.pc, r.instr, r.compressed, r.c_illegal});
  endfunction

  function automatic logic [255:0] imm_view(input trace_record_t r);
    return 256'({r.imm_fmt, r.imm});
  endfunction

  function automatic logic [255:0] reg_view(input trace_record_t r);
    return 256'({r.rs1, r.rs2, r.rs3, r.rs1_value, r.rs2_value, r.rs3_value,
                 r.rd, r.rd_value, r.rd2_valid, r.rd2, r.rd2_value});
  endfunction

  function automatic logic [255:0] mem_view(input trace_record_t r);
    return 256'({r.mem_kind, r.mem_addr, r.mem_data});
  endfunction

  function automatic logic [255:0] stamp_view(input trace_record_t r);
    return 256'({r.hart_id, r.cycle});
  endfunction

  task automatic report(input logic [2:0] id, input string field,
                        input logic [255:0] exp, input logic [255:0] act);
    errors = errors + 1;
    $display("[ERROR] %s %s: expected %0h actual %0h", test_name(id), field, exp, act);
  endtask

  task automatic plain_error(input string msg);
    errors = errors + 1;
    $display("Error: %s", msg);
  endtask

  // Drive one retirement, sometimes followed by an idle cycle
  task automatic retire(input logic [2:0] id, input rvfi_retire_t r, input xlen_word_t ins,
                        input logic comp, input logic ill);
    xlen_word_t g;
    @(posedge clk_i);
    #1;
    cur_test     = id;
    rvfi_i       = r;
    rvfi_valid_i = 1'b1;
    exp_d        = model_record(r, ins, comp, ill);
    issued       = issued + 1;
    g = rand32();
    if (g[2:0] == 3'd0) begin
      @(posedge clk_i);
      #1 rvfi_valid_i = 1'b0;
    end
  endtask

  always_comb begin
    exp_next       = exp_d;
    exp_next.cycle = tb_cycle;
  end

  // One-entry expected pipeline and event tallies
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      tb_cycle <= '0;
      strobe_q <= 1'b0;
      exp_q    <= '0;
      test_q   <= T_RESET;
      tally_q  <= '0;
      seen     <= 0;
    end else begin
      tb_cycle <= tb_cycle + 32'd1;
      strobe_q <= rvfi_valid_i;
      if (rvfi_valid_i) begin
        exp_q  <= exp_next;
        test_q <= cur_test;
      end
      if (trace_valid_o) begin
        seen <= seen + 1;
      end
      if (strobe_q) begin
        tally_q.retired    <= tally_q.retired + 32'd1;
        tally_q.compressed <= tally_q.compressed + 32'(exp_q.compressed);
        tally_q.c_illegal  <= tally_q.c_illegal + 32'(exp_q.c_illegal);
        tally_q.loads      <= tally_q.loads + 32'(exp_q.mem_kind == MEM_LOAD);
        tally_q.stores     <= tally_q.stores + 32'(exp_q.mem_kind == MEM_STORE);
        tally_q.fp_writes  <= tally_q.fp_writes + 32'(exp_q.rd[5]) +
                              32'(exp_q.rd2_valid & exp_q.rd2[5]);
      end
    end
  end

  always @(posedge clk_i) begin
    cyc <= cyc + 1;
    if (cyc == TIMEOUT_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  reset_quiet_a: assert property (@(posedge clk_i)
    (!rst_ni && cyc != 0) |-> (!trace_valid_o && stats_o == '0))
    else plain_error("trace valid or a statistics count was nonzero during reset");

  valid_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    trace_valid_o == strobe_q)
    else report($sampled(test_q), "trace_valid", 256'($sampled(strobe_q)),
                256'($sampled(trace_valid_o)));

  instr_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    trace_valid_o |-> instr_view(trace_o) == instr_view(exp_q))
    else report($sampled(test_q), "pc/instr/flags", instr_view($sampled(exp_q)),
                instr_view($sampled(trace_o)));

  imm_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    trace_valid_o |-> imm_view(trace_o) == imm_view(exp_q))
    else report($sampled(test_q), "imm_fmt/imm", imm_view($sampled(exp_q)),
                imm_view($sampled(trace_o)));

  regs_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    trace_valid_o |-> reg_view(trace_o) == reg_view(exp_q))
    else report($sampled(test_q), "registers", reg_view($sampled(exp_q)),
                reg_view($sampled(trace_o)));

  mem_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    trace_valid_o |-> mem_view(trace_o) == mem_view(exp_q))
    else report($sampled(test_q), "memory", mem_view($sampled(exp_q)),
                mem_view($sampled(trace_o)));

  stamp_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    trace_valid_o |-> stamp_view(trace_o) == stamp_view(exp_q))
    else report($sampled(test_q), "hart/cycle", stamp_view($sampled(exp_q)),
                stamp_view($sampled(trace_o)));

  // Counts trail each record by one cycle, just like the tallies
  stats_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    stats_o == tally_q)
    else report($sampled(test_q), "stats", 256'($sampled(tally_q)), 256'($sampled(stats_o)));

  initial begin
    xlen_word_t ins;
    clk_i        = 1'b0;
    rst_ni       = 1'b0;
    hart_id_i    = HART_ID;
    rvfi_valid_i = 1'b0;
    rvfi_i       = '0;
    exp_d        = '0;
    cur_test     = T_RESET;
    repeat (8) @(posedge clk_i);
    #1 rst_ni = 1'b1;
    repeat (2) @(posedge clk_i);

    for (int i = 0; i < N_UNCOMP; i++) begin
      ins = random_insn();
      retire(T_UNCOMP, random_retire(ins), ins, 1'b0, 1'b0);
    end
    for (int i = 0; i < N_TABLE; i++) begin
      ins = {16'h0000, c_half[i]};
      retire(T_COMP, random_retire(ins), c_word[i], 1'b1, c_half[i] == 16'h0000);
    end
    for (int i = 0; i < N_MERGE; i++) begin
      ins = random_insn();
      retire(T_MERGE, random_retire(ins), ins, 1'b0, 1'b0);
    end
    for (int i = 0; i < N_MEM; i++) begin
      ins = random_insn();
      retire(T_MEM, random_retire(ins), ins, 1'b0, 1'b0);
    end

    @(posedge clk_i);
    #1 rvfi_valid_i = 1'b0;
    repeat (4) @(posedge clk_i);
    #1;
    record_count: assert (seen == issued)
      else plain_error($sformatf("%0d records seen for %0d retirements", seen, issued));

    $display("Retirements: %0d, records: %0d, errors: %0d", issued, seen, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== flist.f ====
common/trace_pkg.sv
trace/compressed_decoder.sv
trace/trace_record_builder.sv
src/trace_stats.sv
src/rvfi_trace_top.sv
tb/tb_rvfi_trace.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_rvfi_trace
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "RESULT: PASS" $(LOG); then echo "No result in $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
